// File: design/event_unit_pkg.sv
// Single 32-bit event word, bit 31 of STATUS is the emergency flag, core count fixed at 2
package event_unit_pkg;

   // ******************************************************************
   // Sizes
   // ******************************************************************
   // Cores served by the unit
   localparam int NUM_CORES   = 2;
   localparam int EVT_W       = 32;
   // Emergency flag position in the STATUS read word
   localparam int EMERG_BIT   = 31;
   localparam int GP_W        = 8;
   localparam int TMR_W       = 4;
   localparam int EXT_W       = 8;
   localparam int ADR_W       = 8;
   localparam int DAT_W       = 32;
   // Per-core register window, core n at n * CORE_STRIDE
   localparam int CORE_STRIDE = 32'h20;
   localparam int OFS_W       = $clog2(CORE_STRIDE);

   typedef logic [EVT_W-1:0] event_vec_t;
   typedef logic [ADR_W-1:0] wb_adr_t;
   typedef logic [DAT_W-1:0] wb_dat_t;

   // Register offsets inside a core window
   localparam logic [OFS_W-1:0] REG_MASK   = 'h00;
   localparam logic [OFS_W-1:0] REG_STATUS = 'h04;
   localparam logic [OFS_W-1:0] REG_CLEAR  = 'h08;
   localparam logic [OFS_W-1:0] REG_SLEEP  = 'h0C;
   localparam logic [OFS_W-1:0] REG_EMCLR  = 'h10;

   // Event sources, MSB first so barrier lands on bit 0
   typedef struct packed {
      logic [EXT_W-1:0] ext;
      logic             hwce;
      logic             dma;
      logic [TMR_W-1:0] tmr;
      logic [GP_W-1:0]  gp;
      logic             barrier;
   } evt_src_t;

   // Wishbone classic, master side
   typedef struct packed {
      logic    cyc;
      logic    stb;
      logic    we;
      wb_adr_t adr;
      wb_dat_t dat;
   } wb_req_t;

   // Wishbone classic, slave side
   typedef struct packed {
      logic    ack;
      wb_dat_t dat;
   } wb_rsp_t;

   typedef enum logic {RUN, SLEEP} sleep_state_t;

endpackage

// File: design/event_unit_mux.sv
// Rising edges only count as events; a clear wins over a simultaneous edge of the same bit
`timescale 1ns/10ps

module event_unit_mux (
   input  logic                       clk_i,
   input  logic                       rst_ni,
   input  event_unit_pkg::event_vec_t evt_i,
   input  logic                       emergency_i,
   input  logic                       mask_we_i,
   input  event_unit_pkg::event_vec_t mask_i,
   input  event_unit_pkg::event_vec_t clear_i,
   input  logic                       emerg_clear_i,
   output event_unit_pkg::event_vec_t mask_o,
   output event_unit_pkg::event_vec_t status_o,
   output logic                       emerg_status_o,
   output logic                       detect_o
);

   import event_unit_pkg::*;

   // Previous samples for edge detection
   event_vec_t evt_q;
   logic       emerg_q;
   // Rising edges seen this cycle
   event_vec_t evt_rise;
   logic       emerg_rise;
   // Buffered events and the per-core mask
   event_vec_t evt_buf_q;
   event_vec_t mask_q;
   logic       emerg_buf_q;

   // ******************************************************************
   // Edge detection
   // ******************************************************************
   always_ff @(posedge clk_i, negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         evt_q   <= '0;
         emerg_q <= 1'b0;
      end
      else
      begin
         evt_q   <= evt_i;
         emerg_q <= emergency_i;
      end
   end

   // High now, low at the previous edge
   assign evt_rise   = evt_i & ~evt_q;
   assign emerg_rise = emergency_i & ~emerg_q;

   // ******************************************************************
   // Buffers and mask
   // ******************************************************************
   always_ff @(posedge clk_i, negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         evt_buf_q   <= '0;
         emerg_buf_q <= 1'b0;
         mask_q      <= '0;
      end
      else
      begin
         // New edges merge into pending bits, clear masks both
         evt_buf_q   <= (evt_buf_q | evt_rise) & ~clear_i;
         emerg_buf_q <= (emerg_buf_q | emerg_rise) & ~emerg_clear_i;
         if (mask_we_i)
         begin
            mask_q <= mask_i;
         end
      end
   end

   assign mask_o         = mask_q;
   // Masked view recomputed from buffer, so a mask write exposes old edges
   assign status_o       = evt_buf_q & mask_q;
   assign emerg_status_o = emerg_buf_q;
   // Emergency bypasses the mask
   assign detect_o       = (|status_o) | emerg_buf_q;

   // Nothing reported outside the mask
   a_status_in_mask: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (status_o & ~mask_o) == '0);

   // A cleared bit is gone one cycle later, even with a coincident rise
   a_clear_wins: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (clear_i != '0) |=> ((evt_buf_q & $past(clear_i)) == '0));

endmodule

// File: design/event_unit_regs.sv
// Wishbone classic single access, one-cycle ack, unmapped offsets and cores read zero
`timescale 1ns/10ps

module event_unit_regs (
   input  logic                                   clk_i,
   input  logic                                   rst_ni,
   input  event_unit_pkg::wb_req_t                wb_i,
   input  event_unit_pkg::event_vec_t             mask_i [event_unit_pkg::NUM_CORES],
   input  event_unit_pkg::event_vec_t             status_i [event_unit_pkg::NUM_CORES],
   input  logic [event_unit_pkg::NUM_CORES-1:0]   emerg_status_i,
   output event_unit_pkg::wb_rsp_t                wb_o,
   output logic [event_unit_pkg::NUM_CORES-1:0]   mask_we_o,
   output event_unit_pkg::event_vec_t             mask_o,
   output event_unit_pkg::event_vec_t             clear_o [event_unit_pkg::NUM_CORES],
   output logic [event_unit_pkg::NUM_CORES-1:0]   emerg_clear_o,
   output logic [event_unit_pkg::NUM_CORES-1:0]   sleep_req_o
);

   import event_unit_pkg::*;

   localparam int CORE_SEL_W = ADR_W - OFS_W;

   // Address split into core window and offset
   logic [CORE_SEL_W-1:0] core_sel;
   logic [OFS_W-1:0]      ofs;
   // New request, not yet acked
   logic                  req;
   logic                  wr;
   logic                  ack_q;
   wb_dat_t               rdata_d;
   wb_dat_t               rdata_q;

   assign core_sel = wb_i.adr[ADR_W-1:OFS_W];
   assign ofs      = wb_i.adr[OFS_W-1:0];
   // Ack gates req so the still-high stb does not start a second access
   assign req      = wb_i.cyc & wb_i.stb & ~ack_q;
   assign wr       = req & wb_i.we;

   // Write data goes to every mux, the we strobe picks the core
   assign mask_o = wb_i.dat;

   // ******************************************************************
   // Write strobes, effective on the acking edge
   // ******************************************************************
   always_comb
   begin
      for (int c = 0; c < NUM_CORES; c++)
      begin
         mask_we_o[c]     = 1'b0;
         clear_o[c]       = '0;
         emerg_clear_o[c] = 1'b0;
         sleep_req_o[c]   = 1'b0;
         if (wr && core_sel == CORE_SEL_W'(c))
         begin
            case (ofs)
               REG_MASK:  mask_we_o[c]     = 1'b1;
               // Ones in the data select bits to drop
               REG_CLEAR: clear_o[c]       = wb_i.dat;
               REG_EMCLR: emerg_clear_o[c] = 1'b1;
               REG_SLEEP: sleep_req_o[c]   = 1'b1;
               default:   mask_we_o[c]     = 1'b0;
            endcase
         end
      end
   end

   // ******************************************************************
   // Read mux
   // ******************************************************************
   always_comb
   begin
      rdata_d = '0;
      for (int c = 0; c < NUM_CORES; c++)
      begin
         if (core_sel == CORE_SEL_W'(c))
         begin
            case (ofs)
               REG_MASK: rdata_d = mask_i[c];
               REG_STATUS:
               begin
                  rdata_d            = status_i[c];
                  rdata_d[EMERG_BIT] = emerg_status_i[c];
               end
               default:  rdata_d = '0;
            endcase
         end
      end
   end

   always_ff @(posedge clk_i, negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         ack_q <= 1'b0;
      end
      else
      begin
         ack_q <= req;
      end
   end

   // Read data held for the ack cycle
   always_ff @(posedge clk_i)
   begin
      if (req && !wb_i.we)
      begin
         rdata_q <= rdata_d;
      end
   end

   assign wb_o = '{ack: ack_q, dat: rdata_q};

   // Single-cycle ack per access
   a_ack_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
      ack_q |=> !ack_q);

   // Master keeps the cycle open until ack
   a_ack_in_cyc: assert property (@(posedge clk_i) disable iff (!rst_ni)
      ack_q |-> wb_i.cyc);

endmodule

// File: design/event_unit_sleep_ctrl.sv
// Produces an enable only, no clock gating cell; a sleep request with a pending event is dropped
`timescale 1ns/10ps

module event_unit_sleep_ctrl (
   input  logic clk_i,
   input  logic rst_ni,
   input  logic sleep_req_i,
   input  logic wake_i,
   output logic clk_en_o
);

   import event_unit_pkg::*;

   sleep_state_t state_q;
   sleep_state_t state_d;

   // ******************************************************************
   // Run/sleep FSM
   // ******************************************************************
   always_comb
   begin
      state_d = state_q;
      case (state_q)
         RUN:
         begin
            // Pending event blocks the request
            if (sleep_req_i && !wake_i)
            begin
               state_d = SLEEP;
            end
         end
         SLEEP:
         begin
            if (wake_i)
            begin
               state_d = RUN;
            end
         end
         default: state_d = RUN;
      endcase
   end

   // Cores come out of reset running
   always_ff @(posedge clk_i, negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         state_q <= RUN;
      end
      else
      begin
         state_q <= state_d;
      end
   end

   assign clk_en_o = (state_q == RUN);

   // Detect at an edge ends sleep on that edge
   a_wake: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (state_q == SLEEP && wake_i) |=> (state_q == RUN));

endmodule

// File: design/event_unit_top.sv
// Lower 32-bit event half only; all sources and the emergency line are shared by every core
`timescale 1ns/10ps

module event_unit_top (
   input  logic                                 clk_i,
   input  logic                                 rst_ni,
   input  event_unit_pkg::wb_req_t              wb_i,
   input  event_unit_pkg::evt_src_t             evt_i,
   input  logic                                 emergency_i,
   output event_unit_pkg::wb_rsp_t              wb_o,
   output logic [event_unit_pkg::NUM_CORES-1:0] irq_o,
   output logic [event_unit_pkg::NUM_CORES-1:0] core_clk_en_o
);

   import event_unit_pkg::*;

   // Unused upper bits of the event word
   localparam int PAD_W = EVT_W - $bits(evt_src_t);

   event_vec_t             evt_vec;
   event_vec_t             mask_wdata;
   event_vec_t             mask_rd [NUM_CORES];
   event_vec_t             status [NUM_CORES];
   event_vec_t             clear [NUM_CORES];
   logic [NUM_CORES-1:0]   mask_we;
   logic [NUM_CORES-1:0]   emerg_status;
   logic [NUM_CORES-1:0]   emerg_clear;
   logic [NUM_CORES-1:0]   sleep_req;
   logic [NUM_CORES-1:0]   detect;

   // Barrier at bit 0, then gp, tmr, dma, hwce, ext
   assign evt_vec = {{PAD_W{1'b0}}, evt_i.ext, evt_i.hwce, evt_i.dma,
                     evt_i.tmr, evt_i.gp, evt_i.barrier};

   event_unit_regs u_regs (
      .clk_i          (clk_i),
      .rst_ni         (rst_ni),
      .wb_i           (wb_i),
      .mask_i         (mask_rd),
      .status_i       (status),
      .emerg_status_i (emerg_status),
      .wb_o           (wb_o),
      .mask_we_o      (mask_we),
      .mask_o         (mask_wdata),
      .clear_o        (clear),
      .emerg_clear_o  (emerg_clear),
      .sleep_req_o    (sleep_req)
   );

   // ******************************************************************
   // Per-core slices
   // ******************************************************************
   for (genvar g = 0; g < NUM_CORES; g++)
   begin : g_core
      event_unit_mux u_mux (
         .clk_i          (clk_i),
         .rst_ni         (rst_ni),
         .evt_i          (evt_vec),
         .emergency_i    (emergency_i),
         .mask_we_i      (mask_we[g]),
         .mask_i         (mask_wdata),
         .clear_i        (clear[g]),
         .emerg_clear_i  (emerg_clear[g]),
         .mask_o         (mask_rd[g]),
         .status_o       (status[g]),
         .emerg_status_o (emerg_status[g]),
         .detect_o       (detect[g])
      );

      event_unit_sleep_ctrl u_sleep (
         .clk_i       (clk_i),
         .rst_ni      (rst_ni),
         .sleep_req_i (sleep_req[g]),
         .wake_i      (detect[g]),
         .clk_en_o    (core_clk_en_o[g])
      );
   end

   assign irq_o = detect;

endmodule

// File: testbench/tb_clock_gen.sv
// 20 ns clock from time zero; active-low reset held for 16 cycles, released on a falling edge
`timescale 1ns/10ps

module tb_clock_gen (
   output logic clk_o,
   output logic rst_no
);

   localparam int HALF_PERIOD_NS = 10;
   localparam int RESET_CYCLES   = 16;

   initial
   begin
      clk_o = 1'b0;
      forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
   end

   // Release away from the rising edge
   initial
   begin
      rst_no = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      @(negedge clk_o);
      rst_no = 1'b1;
   end

endmodule

// File: testbench/tb_event_unit.sv
// Expected values come from a model in this testbench; random stimulus uses seed 21
`timescale 1ns/10ps

module tb_event_unit;

   import event_unit_pkg::*;

   // ******************************************************************
   // Run length and limits
   // ******************************************************************
   localparam int CLK_PERIOD_NS = 20;
   // Generous bound on all tests, plus margin
   localparam int TEST_CYCLES   = 16000;
   localparam int MARGIN_CYCLES = 4000;
   localparam int WATCHDOG_NS   = (TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD_NS;
   localparam int ACK_LIMIT     = 8;
   localparam int ROUNDS        = 6;
   // Bits 0..22 carry real sources
   localparam event_vec_t SRC_BITS = 32'h007F_FFFF;

   logic                 clk_i;
   logic                 rst_ni;
   wb_req_t              wb_req;
   wb_rsp_t              wb_rsp;
   evt_src_t             evt_src;
   logic                 emergency;
   logic [NUM_CORES-1:0] irq;
   logic [NUM_CORES-1:0] clk_en;
   event_vec_t           src_vec;
   wb_dat_t              rdata;
   string                test_name;
   int                   seed;

   // Reference model state
   event_vec_t           m_prev;
   logic                 m_emerg_prev;
   logic                 m_ack;
   event_vec_t           m_buf [NUM_CORES];
   event_vec_t           m_mask [NUM_CORES];
   logic                 m_emerg [NUM_CORES];
   logic                 m_asleep [NUM_CORES];
   logic [NUM_CORES-1:0] m_irq;
   logic [NUM_CORES-1:0] m_en;

   tb_clock_gen clk_gen0 (
      .clk_o  (clk_i),
      .rst_no (rst_ni)
   );

   event_unit_top dut0 (
      .clk_i         (clk_i),
      .rst_ni        (rst_ni),
      .wb_i          (wb_req),
      .evt_i         (evt_src),
      .emergency_i   (emergency),
      .wb_o          (wb_rsp),
      .irq_o         (irq),
      .core_clk_en_o (clk_en)
   );

   task automatic stop_on_error(input string line);
      $display("%s", line);
      $display("Testbench failed");
      $fatal(1);
   endtask

   // Field order from bit 0: barrier, gp, tmr, dma, hwce, ext
   function automatic evt_src_t to_sources(input event_vec_t v);
      evt_src_t s;
      s.barrier = v[0];
      s.gp      = v[8:1];
      s.tmr     = v[12:9];
      s.dma     = v[13];
      s.hwce    = v[14];
      s.ext     = v[22:15];
      return s;
   endfunction

   task automatic drive_sources(input event_vec_t v);
      src_vec = v & SRC_BITS;
      evt_src = to_sources(src_vec);
   endtask

   function automatic wb_adr_t reg_addr(input int core, input logic [OFS_W-1:0] ofs);
      return wb_adr_t'(core * CORE_STRIDE + int'(ofs));
   endfunction

   // Register view as software should see it before the next edge
   function automatic wb_dat_t expected_read(input int core, input logic [OFS_W-1:0] ofs);
      wb_dat_t d;
      d = '0;
      if (ofs == REG_MASK)
      begin
         d = m_mask[core];
      end
      else if (ofs == REG_STATUS)
      begin
         d            = m_buf[core] & m_mask[core];
         d[EMERG_BIT] = m_emerg[core];
      end
      return d;
   endfunction

   // ******************************************************************
   // Wishbone master, called on a falling edge
   // ******************************************************************
   task automatic bus_cycle(input logic we, input wb_adr_t adr, input wb_dat_t wdat,
                            output wb_dat_t rdat);
      int waited;
      wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
      waited = 0;
      while (!wb_rsp.ack && waited < ACK_LIMIT)
      begin
         @(negedge clk_i);
         waited++;
      end
      if (!wb_rsp.ack)
      begin
         stop_on_error($sformatf("No ack from the slave in %s at address %h", test_name, adr));
      end
      else
      begin
         rdat = wb_rsp.dat;
         // Cycle stays open through the edge that samples ack
         @(negedge clk_i);
         wb_req = '0;
      end
   endtask

   task automatic write_reg(input int core, input logic [OFS_W-1:0] ofs, input wb_dat_t d);
      wb_dat_t unused;
      @(negedge clk_i);
      bus_cycle(1'b1, reg_addr(core, ofs), d, unused);
   endtask

   task automatic check_read(input int core, input logic [OFS_W-1:0] ofs);
      wb_dat_t exp;
      wb_dat_t act;
      @(negedge clk_i);
      exp = expected_read(core, ofs);
      bus_cycle(1'b0, reg_addr(core, ofs), '0, act);
      a_read: assert (act === exp)
         else stop_on_error($sformatf("ERR %s: core %0d offset %h expected %h, actual %h",
                                      test_name, core, ofs, exp, act));
   endtask

   // One-cycle pulse on the given sources
   task automatic pulse_sources(input event_vec_t v);
      @(negedge clk_i);
      drive_sources(v);
      @(negedge clk_i);
      drive_sources('0);
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) @(negedge clk_i);
   endtask

   // ******************************************************************
   // Reference model, one step per rising edge
   // ******************************************************************
   always @(posedge clk_i or negedge rst_ni)
   begin
      event_vec_t       rise;
      logic             emerg_rise;
      logic             wr;
      logic             pending;
      int               sel;
      logic [OFS_W-1:0] ofs;
      if (!rst_ni)
      begin
         m_prev       = '0;
         m_emerg_prev = 1'b0;
         m_ack        = 1'b0;
         for (int c = 0; c < NUM_CORES; c++)
         begin
            m_buf[c]    = '0;
            m_mask[c]   = '0;
            m_emerg[c]  = 1'b0;
            m_asleep[c] = 1'b0;
         end
      end
      else
      begin
         rise       = src_vec & ~m_prev;
         emerg_rise = emergency & ~m_emerg_prev;
         // Write lands on the edge that raises ack
         wr         = wb_req.cyc & wb_req.stb & wb_req.we & ~m_ack;
         sel        = int'(wb_req.adr[ADR_W-1:OFS_W]);
         ofs        = wb_req.adr[OFS_W-1:0];
         for (int c = 0; c < NUM_CORES; c++)
         begin
            // Detect as it stood before this edge
            pending    = ((m_buf[c] & m_mask[c]) != '0) || m_emerg[c];
            m_buf[c]   = m_buf[c] | rise;
            m_emerg[c] = m_emerg[c] | emerg_rise;
            if (wr && sel == c)
            begin
               case (ofs)
                  REG_MASK:  m_mask[c]   = wb_req.dat;
                  // Clear applied after merge, so it wins
                  REG_CLEAR: m_buf[c]    = m_buf[c] & ~wb_req.dat;
                  REG_EMCLR: m_emerg[c]  = 1'b0;
                  REG_SLEEP: m_asleep[c] = !pending;
                  default:   m_asleep[c] = m_asleep[c];
               endcase
            end
            if (pending)
            begin
               m_asleep[c] = 1'b0;
            end
         end
         m_ack        = wb_req.cyc & wb_req.stb & ~m_ack;
         m_prev       = src_vec;
         m_emerg_prev = emergency;
      end
      for (int c = 0; c < NUM_CORES; c++)
      begin
         m_irq[c] = ((m_buf[c] & m_mask[c]) != '0) || m_emerg[c];
         m_en[c]  = !m_asleep[c];
      end
   end

   // Outputs depend on registers only, so the falling edge sees them settled
   a_irq_match: assert property (@(negedge clk_i) disable iff (!rst_ni) irq == m_irq)
      else stop_on_error($sformatf("ERR %s: irq_o expected %b, actual %b",
                                   test_name, m_irq, irq));

   a_clk_en_match: assert property (@(negedge clk_i) disable iff (!rst_ni) clk_en == m_en)
      else stop_on_error($sformatf("ERR %s: core_clk_en_o expected %b, actual %b",
                                   test_name, m_en, clk_en));

   initial
   begin
      #(WATCHDOG_NS);
      stop_on_error("Watchdog timeout, the tests did not finish in time");
   end

   // ******************************************************************
   // Tests
   // ******************************************************************
   initial
   begin
      seed      = 21;
      test_name = "reset";
      wb_req    = '0;
      emergency = 1'b0;
      drive_sources('0);
      wait (rst_ni === 1'b1);
      for (int c = 0; c < NUM_CORES; c++)
      begin
         check_read(c, REG_MASK);
         check_read(c, REG_STATUS);
      end

      test_name = "mask_readback";
      for (int c = 0; c < NUM_CORES; c++)
      begin
         write_reg(c, REG_MASK, wb_dat_t'($random(seed)));
      end
      // All cores written before any read, so a core decode fault shows up
      for (int c = 0; c < NUM_CORES; c++)
      begin
         check_read(c, REG_MASK);
      end

      test_name = "masked_buffering";
      for (int r = 0; r < ROUNDS; r++)
      begin
         pulse_sources(event_vec_t'($random(seed)));
         check_read(0, REG_STATUS);
         check_read(1, REG_STATUS);
      end
      // Every source once, then open the mask to expose hidden bits
      pulse_sources(SRC_BITS);
      check_read(0, REG_STATUS);
      write_reg(0, REG_MASK, '1);
      check_read(0, REG_STATUS);
      write_reg(0, REG_CLEAR, '1);
      write_reg(1, REG_CLEAR, '1);

      test_name = "edge_clear";
      @(negedge clk_i);
      drive_sources(32'h8);
      idle_cycles(2);
      check_read(0, REG_STATUS);
      // Level still high, no new edge
      write_reg(0, REG_CLEAR, 32'h8);
      idle_cycles(3);
      check_read(0, REG_STATUS);
      @(negedge clk_i);
      drive_sources('0);
      // Rise and clear on the same edge
      @(negedge clk_i);
      drive_sources(32'h8);
      bus_cycle(1'b1, reg_addr(0, REG_CLEAR), 32'h8, rdata);
      check_read(0, REG_STATUS);
      @(negedge clk_i);
      drive_sources('0);
      pulse_sources(32'h8);
      check_read(0, REG_STATUS);
      write_reg(0, REG_CLEAR, '1);
      write_reg(1, REG_CLEAR, '1);

      test_name = "emergency";
      write_reg(1, REG_MASK, '0);
      @(negedge clk_i);
      emergency = 1'b1;
      idle_cycles(2);
      check_read(0, REG_STATUS);
      check_read(1, REG_STATUS);
      @(negedge clk_i);
      emergency = 1'b0;
      write_reg(0, REG_EMCLR, '0);
      check_read(0, REG_STATUS);
      check_read(1, REG_STATUS);
      write_reg(1, REG_EMCLR, '0);

      test_name = "sleep_wake";
      write_reg(0, REG_SLEEP, '0);
      idle_cycles(4);
      // Barrier is enabled in core 0's mask
      pulse_sources(32'h1);
      idle_cycles(2);
      write_reg(0, REG_SLEEP, '0);
      idle_cycles(4);
      write_reg(0, REG_CLEAR, '1);
      write_reg(1, REG_CLEAR, '1);
      idle_cycles(2);

      $display("Testbench passed");
      $finish;
   end

endmodule

// File: verilog.f
design/event_unit_pkg.sv
design/event_unit_mux.sv
design/event_unit_regs.sv
design/event_unit_sleep_ctrl.sv
design/event_unit_top.sv
testbench/tb_clock_gen.sv
testbench/tb_event_unit.sv

// File: Makefile
# Verilator build and run of the event unit testbench
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_event_unit
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

# The run exits nonzero on any $$fatal, so make reports the failure
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
